// File: Bender.yml
package:
  name: pe_simd

sources:
  - include_dirs:
      - source
    files:
      - source/pe_pkg.sv
      - source/pe_apb_regs.sv
      - source/pe_control.sv
      - source/pe_dsp_lane.sv
      - source/pe_writeback.sv
      - source/pe_top.sv
  - target: test
    include_dirs:
      - source
      - tb
    files:
      - tb/pe_tb.sv

// File: all.f
+incdir+source
+incdir+tb
source/pe_pkg.sv
source/pe_apb_regs.sv
source/pe_control.sv
source/pe_dsp_lane.sv
source/pe_writeback.sv
source/pe_top.sv
tb/pe_tb.sv

// File: source/pe_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_macros.svh"

module pe_apb_regs (
    input  wire                    clk,
    input  wire                    reset,
    // apb slave
    input  wire                    psel,
    input  wire                    penable,
    input  wire                    pwrite,
    input  wire  [`PE_APB_AW-1:0]  paddr,
    input  wire  [`PE_APB_DW-1:0]  pwdata,
    output logic [`PE_APB_DW-1:0]  prdata,
    output logic                   pready,
    output logic                   pslverr,
    // from writeback
    input  wire  [`PE_VEC_W-1:0]   result,
    input  wire                    done,
    // to datapath
    output logic [`PE_VEC_W-1:0]   opa,
    output logic [`PE_VEC_W-1:0]   opb,
    output logic [`PE_INST_W-1:0]  inst,
    output logic                   issue,
    output logic                   busy
);

    logic acc;       // access phase
    logic wr;
    logic addr_hit;  // mapped offset
    logic inst_wr;
    logic inst_ok;   // accepted instruction write
    logic done_r;    // sticky, host polls this

    assign acc     = psel & penable;
    assign wr      = acc & pwrite;
    assign inst_wr = wr && (paddr == `PE_REG_INST);
    assign inst_ok = inst_wr && !busy;

    assign pready  = 1'b1;  // zero wait states
    assign pslverr = acc && (!addr_hit || (inst_wr && busy));

    //////////////////////////////////////////////////
    // address decode and readback
    //////////////////////////////////////////////////

    always_comb begin
        addr_hit = 1'b1;
        prdata   = '0;
        case (paddr)
            `PE_REG_OPA0:   prdata = opa[`PE_APB_DW-1:0];
            `PE_REG_OPA1:   prdata = opa[`PE_VEC_W-1:`PE_APB_DW];
            `PE_REG_OPB0:   prdata = opb[`PE_APB_DW-1:0];
            `PE_REG_OPB1:   prdata = opb[`PE_VEC_W-1:`PE_APB_DW];
            `PE_REG_INST:   prdata = inst;
            `PE_REG_RES0:   prdata = result[`PE_APB_DW-1:0];
            `PE_REG_RES1:   prdata = result[`PE_VEC_W-1:`PE_APB_DW];
            `PE_REG_STATUS: prdata = {{(`PE_APB_DW-2){1'b0}}, done_r, busy};
            default:        addr_hit = 1'b0;  // unmapped, slverr
        endcase
    end

    // operand and instruction storage
    always_ff @(posedge clk) begin
        if (wr) begin
            case (paddr)
                `PE_REG_OPA0: opa[`PE_APB_DW-1:0]          <= pwdata;
                `PE_REG_OPA1: opa[`PE_VEC_W-1:`PE_APB_DW]  <= pwdata;
                `PE_REG_OPB0: opb[`PE_APB_DW-1:0]          <= pwdata;
                `PE_REG_OPB1: opb[`PE_VEC_W-1:`PE_APB_DW]  <= pwdata;
                default: ;                                 // res and status are read only
            endcase
        end
        if (inst_ok)
            inst <= pwdata;  // a rejected write keeps the running word
    end

    //////////////////////////////////////////////////
    // issue, busy and done
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            issue  <= 1'b0;
            busy   <= 1'b0;
            done_r <= 1'b0;
        end else begin
            issue <= inst_ok;  // one cycle pulse
            if (inst_ok) begin
                busy   <= 1'b1;
                done_r <= 1'b0;  // cleared by next issue
            end else if (done) begin
                busy   <= 1'b0;
                done_r <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/pe_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_macros.svh"

module pe_control import pe_pkg::*; (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          issue,
    input  wire      [`PE_INST_W-1:0]    inst,
    output alumode_t [`PE_LANES-1:0]     alumode,
    output inmode_t  [`PE_LANES-1:0]     inmode,
    output opmode_t  [`PE_LANES-1:0]     opmode,
    output logic     [`PE_LANES-1:0]     usemult,
    output logic     [`PE_IMM_W-1:0]     imm,
    output logic                         ce_issue,
    output logic                         wb_valid
);

    localparam int unsigned DLY = 1 + `PE_LANE_LAT;  // mode reg + lane stages

    opcode_e     opcode;
    alumode_t    alu_d;
    inmode_t     inm_d;
    opmode_t     opm_d;
    logic        mult_d;
    logic [DLY-1:0] issue_sr;

    assign opcode = opcode_e'(inst[`PE_OPC_MSB:`PE_OPC_LSB]);

    //////////////////////////////////////////////////
    // opcode decode, one lane's worth
    //////////////////////////////////////////////////

    always_comb begin
        // load unless told otherwise
        alu_d  = ALU_ADD;
        inm_d  = INM_NONE;
        opm_d  = OPM_PASS;
        mult_d = 1'b0;
        case (opcode)
            OP_ADD:  opm_d = OPM_ALU;
            OP_SUB: begin
                alu_d = ALU_SUB;
                opm_d = OPM_ALU;
            end
            OP_MUL: begin
                inm_d  = INM_MREG;
                opm_d  = OPM_MULT;
                mult_d = 1'b1;
            end
            OP_ADDI: begin
                inm_d = INM_IMM;    // imm in place of b
                opm_d = OPM_ALU;
            end
            OP_SUBI: begin
                alu_d = ALU_SUB;
                inm_d = INM_IMM;
                opm_d = OPM_ALU;
            end
            OP_MULI: begin
                inm_d  = INM_MREG | INM_IMM;
                opm_d  = OPM_MULT;
                mult_d = 1'b1;
            end
            default: ;              // load, also 3'b100
        endcase
    end

    // same word to every lane, held until next issue
    always_ff @(posedge clk) begin
        if (reset) begin
            alumode <= '0;
            inmode  <= '0;
            opmode  <= '0;
            usemult <= '0;
        end else if (issue) begin
            alumode <= {`PE_LANES{alu_d}};
            inmode  <= {`PE_LANES{inm_d}};
            opmode  <= {`PE_LANES{opm_d}};
            usemult <= {`PE_LANES{mult_d}};
        end
    end

    always_ff @(posedge clk) begin
        if (issue)
            imm <= inst[`PE_IMM_W-1:0];  // broadcast immediate
    end

    // valid delay line, tap 0 starts the lanes
    always_ff @(posedge clk) begin
        if (reset)
            issue_sr <= '0;
        else
            issue_sr <= {issue_sr[DLY-2:0], issue};
    end

    assign ce_issue = issue_sr[0];
    assign wb_valid = issue_sr[DLY-1];  // lines up with lane p

endmodule

`default_nettype wire

// File: source/pe_dsp_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_macros.svh"

module pe_dsp_lane import pe_pkg::*; (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      ce,       // stage 1 capture
    input  wire      [`PE_LANE_W-1:0] a,
    input  wire      [`PE_LANE_W-1:0] b,
    input  wire      [`PE_IMM_W-1:0]  imm,
    input  wire alumode_t             alumode,
    input  wire inmode_t              inmode,
    input  wire opmode_t              opmode,
    input  wire                      usemult,
    output logic     [`PE_LANE_W-1:0] p
);

    logic [`PE_LANE_W-1:0] b_sel;   // b or imm
    logic [`PE_LANE_W-1:0] a1;
    logic [`PE_LANE_W-1:0] b1;
    logic [`PE_LANE_W-1:0] ma1;     // multiplier input regs
    logic [`PE_LANE_W-1:0] mb1;
    alumode_t              alu1;
    opmode_t               opm1;
    logic                  mult1;
    logic [`PE_LANE_W-1:0] prod_lo;
    logic [`PE_LANE_W-1:0] res2_d;
    logic [`PE_LANE_W-1:0] res2;

    assign b_sel = inmode[INM_IMM_BIT] ? imm : b;

    //////////////////////////////////////////////////
    // stage 1 operand and mode capture
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (ce) begin
            a1 <= a;
            b1 <= b_sel;
            if (inmode[INM_MREG_BIT]) begin
                ma1 <= a;
                mb1 <= b_sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            alu1  <= ALU_ADD;
            opm1  <= OPM_PASS;   // idle lane acts as load
            mult1 <= 1'b0;
        end else if (ce) begin
            alu1  <= alumode;
            opm1  <= opmode;
            mult1 <= usemult;
        end
    end

    // stage 2 compute
    assign prod_lo = ma1 * mb1;  // low 16 bits kept

    always_comb begin
        if (mult1 && (opm1 == OPM_MULT))
            res2_d = prod_lo;
        else if (opm1 == OPM_ALU)
            res2_d = (alu1 == ALU_SUB) ? a1 - b1 : a1 + b1;  // wraps
        else
            res2_d = a1;
    end

    always_ff @(posedge clk) begin
        res2 <= res2_d;
        p    <= res2;   // stage 3 output reg
    end

endmodule

`default_nettype wire

// File: source/pe_macros.svh
`ifndef PE_MACROS_SVH
`define PE_MACROS_SVH

// datapath geometry
`define PE_LANES      4
`define PE_LANE_W     16
`define PE_VEC_W      (`PE_LANES * `PE_LANE_W)   // full operand vector

// instruction word layout
`define PE_INST_W     32
`define PE_OPC_MSB    31
`define PE_OPC_LSB    29
`define PE_IMM_W      16                         // imm sits in bits 15:0

// apb bus widths
`define PE_APB_AW     8
`define PE_APB_DW     32

`define PE_LANE_LAT   3                          // lane pipeline depth

// register map, byte offsets
`define PE_REG_OPA0   8'h00                      // opa lanes 0-1
`define PE_REG_OPA1   8'h04                      // opa lanes 2-3
`define PE_REG_OPB0   8'h08
`define PE_REG_OPB1   8'h0C
`define PE_REG_INST   8'h10                      // write issues
`define PE_REG_RES0   8'h20
`define PE_REG_RES1   8'h24
`define PE_REG_STATUS 8'h28                      // bit 0 busy, bit 1 done

`endif

// File: source/pe_pkg.sv
`default_nettype none

package pe_pkg;

    //////////////////////////////////////////////////
    // opcodes
    //////////////////////////////////////////////////

    // 3'b100 and anything else unlisted falls back to load
    typedef enum logic [2:0] {
        OP_LOAD = 3'b000,
        OP_ADD  = 3'b001,
        OP_SUB  = 3'b010,
        OP_MUL  = 3'b011,
        OP_ADDI = 3'b101,
        OP_SUBI = 3'b110,
        OP_MULI = 3'b111
    } opcode_e;

    //////////////////////////////////////////////////
    // dsp slice mode fields
    //////////////////////////////////////////////////

    typedef logic [3:0] alumode_t;  // alu function
    typedef logic [4:0] inmode_t;   // input path control
    typedef logic [6:0] opmode_t;   // x/y/z mux select

    // alumode codes
    localparam alumode_t ALU_ADD = 4'b0000;   // a + b
    localparam alumode_t ALU_SUB = 4'b0011;   // a - b

    // inmode bits
    localparam int unsigned INM_IMM_BIT  = 0; // broadcast imm replaces lane b
    localparam int unsigned INM_MREG_BIT = 4; // multiplier input regs load

    localparam inmode_t INM_NONE = 5'b00000;
    localparam inmode_t INM_IMM  = 5'b00001;
    localparam inmode_t INM_MREG = 5'b10000;

    // opmode codes
    localparam opmode_t OPM_ALU  = 7'b0110011; // alu on a and b
    localparam opmode_t OPM_MULT = 7'b0000101; // multiplier output
    localparam opmode_t OPM_PASS = 7'b0000000; // pass a through

endpackage

`default_nettype wire

// File: source/pe_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_macros.svh"

module pe_top import pe_pkg::*; (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    psel,
    input  wire                    penable,
    input  wire                    pwrite,
    input  wire  [`PE_APB_AW-1:0]  paddr,
    input  wire  [`PE_APB_DW-1:0]  pwdata,
    output logic [`PE_APB_DW-1:0]  prdata,
    output logic                   pready,
    output logic                   pslverr
);

    logic [`PE_VEC_W-1:0]     opa;
    logic [`PE_VEC_W-1:0]     opb;
    logic [`PE_INST_W-1:0]    inst;
    logic                     issue;
    alumode_t [`PE_LANES-1:0] alumode;
    inmode_t  [`PE_LANES-1:0] inmode;
    opmode_t  [`PE_LANES-1:0] opmode;
    logic     [`PE_LANES-1:0] usemult;
    logic [`PE_IMM_W-1:0]     imm;
    logic                     ce_issue;
    logic                     wb_valid;
    logic [`PE_VEC_W-1:0]     lane_p;
    logic [`PE_VEC_W-1:0]     result;
    logic                     done;

    pe_apb_regs u_regs (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .result  (result),
        .done    (done),
        .opa     (opa),
        .opb     (opb),
        .inst    (inst),
        .issue   (issue),
        .busy    ()        // host sees it through status
    );

    pe_control u_ctrl (
        .clk      (clk),
        .reset    (reset),
        .issue    (issue),
        .inst     (inst),
        .alumode  (alumode),
        .inmode   (inmode),
        .opmode   (opmode),
        .usemult  (usemult),
        .imm      (imm),
        .ce_issue (ce_issue),
        .wb_valid (wb_valid)
    );

    //////////////////////////////////////////////////
    // simd lanes
    //////////////////////////////////////////////////

    for (genvar i = 0; i < `PE_LANES; i++) begin : g_lane
        pe_dsp_lane u_lane (
            .clk     (clk),
            .reset   (reset),
            .ce      (ce_issue),
            .a       (opa[i*`PE_LANE_W +: `PE_LANE_W]),
            .b       (opb[i*`PE_LANE_W +: `PE_LANE_W]),
            .imm     (imm),                              // same for all lanes
            .alumode (alumode[i]),
            .inmode  (inmode[i]),
            .opmode  (opmode[i]),
            .usemult (usemult[i]),
            .p       (lane_p[i*`PE_LANE_W +: `PE_LANE_W])
        );
    end

    pe_writeback u_wb (
        .clk      (clk),
        .reset    (reset),
        .wb_valid (wb_valid),
        .lane_p   (lane_p),
        .result   (result),
        .done     (done)
    );

endmodule

`default_nettype wire

// File: source/pe_writeback.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_macros.svh"

module pe_writeback (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   wb_valid,  // lane outputs valid this cycle
    input  wire  [`PE_VEC_W-1:0]  lane_p,    // lane 0 in the low bits
    output logic [`PE_VEC_W-1:0]  result,
    output logic                  done
);

    //////////////////////////////////////////////////
    // per lane result capture
    //////////////////////////////////////////////////

    for (genvar i = 0; i < `PE_LANES; i++) begin : g_res
        always_ff @(posedge clk) begin
            if (reset)
                result[i*`PE_LANE_W +: `PE_LANE_W] <= '0;  // res reads zero
            else if (wb_valid)
                result[i*`PE_LANE_W +: `PE_LANE_W] <= lane_p[i*`PE_LANE_W +: `PE_LANE_W];
            // else hold for stable readback
        end
    end

    // done follows the capture by one cycle
    always_ff @(posedge clk) begin
        if (reset)
            done <= 1'b0;
        else
            done <= wb_valid;
    end

endmodule

`default_nettype wire

// File: tb/pe_tb_tasks.svh
`ifndef PE_TB_TASKS_SVH
`define PE_TB_TASKS_SVH

//////////////////////////////////////////////////
// apb host side
//////////////////////////////////////////////////

// setup cycle, then one access cycle since pready is tied high
task automatic apb_write(input logic [`PE_APB_AW-1:0] addr, input logic [`PE_APB_DW-1:0] data,
                         output logic err);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    err = pslverr;      // mid access, stable
    @(posedge clk);     // transfer completes here
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

task automatic apb_read(input logic [`PE_APB_AW-1:0] addr, output logic [`PE_APB_DW-1:0] data,
                        output logic err);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    data = prdata;
    err  = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
endtask

// expected result vector, lane by lane
function automatic logic [`PE_VEC_W-1:0] model_result(input logic [2:0] opc,
                                                      input logic [`PE_VEC_W-1:0] a,
                                                      input logic [`PE_VEC_W-1:0] b,
                                                      input logic [15:0] imm);
    logic [`PE_VEC_W-1:0] r;
    logic [15:0] la;
    logic [15:0] lb;
    logic [15:0] lr;
    r = '0;
    for (int i = 0; i < `PE_LANES; i++) begin
        la = a[i*16 +: 16];
        lb = b[i*16 +: 16];
        case (opc)
            OP_ADD:  lr = la + lb;    // 16 bit wrap
            OP_SUB:  lr = la - lb;
            OP_MUL:  lr = la * lb;    // low half of product
            OP_ADDI: lr = la + imm;
            OP_SUBI: lr = la - imm;
            OP_MULI: lr = la * imm;
            default: lr = la;         // load and 3'b100
        endcase
        r[i*16 +: 16] = lr;
    end
    return r;
endfunction

`endif

// File: tb/pe_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_macros.svh"

module pe_tb import pe_pkg::*; ();

    localparam int unsigned TIMEOUT_CYCLES = 3000;  // ~40 instructions at ~60 cycles each
    localparam int unsigned DONE_LIMIT     = 20;    // cycles from inst write to done

    logic                   clk;
    logic                   reset;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`PE_APB_AW-1:0]  paddr;
    logic [`PE_APB_DW-1:0]  pwdata;
    logic [`PE_APB_DW-1:0]  prdata;
    logic                   pready;
    logic                   pslverr;

    int unsigned cycles;
    int unsigned errors;
    int unsigned checks;

    pe_top dut0 (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    `include "pe_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    // run limit
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    // zero wait states, every access phase sees pready
    always @(negedge clk) begin
        if (psel && penable) begin
            assert (pready === 1'b1) else begin
                errors++;
                $display("pready was not high during an APB access phase");
            end
        end
    end

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    // poll status until done, bounded from the inst write
    task automatic wait_done(input string name, input int unsigned start);
        logic [31:0] st;
        logic        err;
        st = '0;
        while (!st[1] && (cycles - start) <= DONE_LIMIT)
            apb_read(`PE_REG_STATUS, st, err);
        checks++;
        assert (st[1] && (cycles - start) <= DONE_LIMIT) else begin
            errors++;
            $display("%s: done was not seen within %0d cycles of the INST write", name, DONE_LIMIT);
        end
    endtask

    task automatic load_operands(input logic [63:0] a, input logic [63:0] b, output logic bad);
        logic err;
        apb_write(`PE_REG_OPA0, a[31:0], err);
        bad = err;
        apb_write(`PE_REG_OPA1, a[63:32], err);
        bad |= err;
        apb_write(`PE_REG_OPB0, b[31:0], err);
        bad |= err;
        apb_write(`PE_REG_OPB1, b[63:32], err);
        bad |= err;
    endtask

    // one full instruction, busy check, done poll, result compare
    task automatic run_op(input string name, input logic [2:0] opc, input logic [63:0] a,
                          input logic [63:0] b, input logic [15:0] imm);
        logic        err;
        logic [31:0] lo;
        logic [31:0] rd;
        int unsigned start;
        load_operands(a, b, err);
        check_val({name, " operand slverr"}, 64'h0, err);
        apb_write(`PE_REG_INST, {opc, 13'd0, imm}, err);
        start = cycles;
        check_val({name, " inst slverr"}, 64'h0, err);
        apb_read(`PE_REG_STATUS, rd, err);
        check_val({name, " status after issue"}, 64'h1, rd);  // busy set, done cleared
        wait_done(name, start);
        apb_read(`PE_REG_RES0, lo, err);
        apb_read(`PE_REG_RES1, rd, err);
        check_val({name, " result"}, model_result(opc, a, b, imm), {rd, lo});
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial begin
        logic [63:0] a;
        logic [63:0] b;
        logic [31:0] rd;
        logic [31:0] lo;
        logic [15:0] imm;
        logic        err;
        int unsigned start;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        reset   = 1'b1;
        errors  = 0;
        checks  = 0;
        void'($urandom(32'he8f4ecf4));
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // reset state
        apb_read(`PE_REG_STATUS, rd, err);
        check_val("reset status", 64'h0, rd);
        apb_read(`PE_REG_RES0, rd, err);
        check_val("reset res0", 64'h0, rd);
        apb_read(`PE_REG_RES1, rd, err);
        check_val("reset res1", 64'h0, rd);

        // register-register ops, then immediates
        for (int i = 0; i < 3; i++) begin
            a   = {$urandom, $urandom};
            b   = {$urandom, $urandom};
            imm = 16'($urandom);
            run_op($sformatf("add %0d", i), OP_ADD, a, b, imm);
            run_op($sformatf("sub %0d", i), OP_SUB, a, b, imm);
            run_op($sformatf("mul %0d", i), OP_MUL, a, b, imm);
            run_op($sformatf("addi %0d", i), OP_ADDI, a, b, imm);
            run_op($sformatf("subi %0d", i), OP_SUBI, a, b, imm);
            run_op($sformatf("muli %0d", i), OP_MULI, a, b, imm);
        end
        run_op("add wrap", OP_ADD, {4{16'hffff}}, {4{16'h0002}}, 16'h0);
        run_op("sub wrap", OP_SUB, {4{16'h0000}}, {4{16'h0001}}, 16'h0);
        run_op("mul trunc", OP_MUL, {4{16'h8001}}, {4{16'h0003}}, 16'h0);

        // load and an unlisted code both pass a
        a = {$urandom, $urandom};
        b = {$urandom, $urandom};
        run_op("load", OP_LOAD, a, b, 16'h1234);
        run_op("opcode 100", 3'b100, a, b, 16'h5678);

        // second inst write while busy is refused
        a = {$urandom, $urandom};
        b = {$urandom, $urandom};
        load_operands(a, b, err);
        apb_write(`PE_REG_INST, {OP_ADD, 29'd0}, err);
        start = cycles;
        apb_write(`PE_REG_INST, {OP_SUB, 29'd0}, err);
        check_val("inst while busy slverr", 64'h1, err);
        wait_done("busy reject", start);
        apb_read(`PE_REG_RES0, lo, err);
        apb_read(`PE_REG_RES1, rd, err);
        check_val("busy reject result", model_result(OP_ADD, a, b, 16'h0), {rd, lo});

        // unmapped offsets
        apb_read(8'h30, rd, err);
        check_val("unmapped read slverr", 64'h1, err);
        apb_write(8'h14, 32'hdead_beef, err);
        check_val("unmapped write slverr", 64'h1, err);

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
